/* hdl/lsu_pkg.sv */
package lsu_pkg;

  // --------------------------------------------------
  // widths
  // --------------------------------------------------
  localparam int unsigned XLEN          = 32;
  localparam int unsigned NR_BYTES      = XLEN / 8;
  localparam int unsigned OFFSET_BITS   = $clog2(NR_BYTES);
  localparam int unsigned TRANS_ID_BITS = 3;

  // data word or virtual address
  typedef logic [XLEN-1:0] xlen_t;

  // one enable per byte lane
  typedef logic [NR_BYTES-1:0] be_t;

  // scoreboard slot the result goes back to
  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  typedef logic [3:0] cause_t;

  // transfer size, byte/half/word
  typedef logic [1:0] size_t;

  // --------------------------------------------------
  // exception causes (mcause encoding)
  // --------------------------------------------------
  localparam cause_t CAUSE_LD_MISALIGNED   = 4'd4;
  localparam cause_t CAUSE_LD_ACCESS_FAULT = 4'd5;
  localparam cause_t CAUSE_ST_MISALIGNED   = 4'd6;
  localparam cause_t CAUSE_ST_ACCESS_FAULT = 4'd7;

  // --------------------------------------------------
  // operations
  // --------------------------------------------------
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  localparam size_t SIZE_BYTE = 2'b00;
  localparam size_t SIZE_HALF = 2'b01;
  localparam size_t SIZE_WORD = 2'b10;

endpackage

/* hdl/lsu_agu.sv */
`timescale 1ns/1ps

module lsu_agu #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_valid_i,
  input  lsu_pkg::lsu_op_e   lsu_op_i,
  input  lsu_pkg::xlen_t     operand_a_i,
  input  lsu_pkg::xlen_t     imm_i,
  input  lsu_pkg::xlen_t     operand_b_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  output logic               valid_o,
  output lsu_pkg::lsu_op_e   op_o,
  output lsu_pkg::xlen_t     vaddr_o,
  output lsu_pkg::be_t       be_o,
  output lsu_pkg::xlen_t     wdata_o,
  output lsu_pkg::trans_id_t trans_id_o,
  output logic               ex_valid_o,
  output lsu_pkg::cause_t    ex_cause_o
);

  // first byte past the scratchpad
  localparam lsu_pkg::xlen_t MEM_BYTES = lsu_pkg::xlen_t'(MEM_WORDS * lsu_pkg::NR_BYTES);

  lsu_pkg::xlen_t  vaddr;
  lsu_pkg::size_t  size;
  lsu_pkg::be_t    be;
  lsu_pkg::cause_t cause;
  logic            is_store;
  logic            misaligned;
  logic            access_fault;

  // --------------------------------------------------
  // address and byte enables
  // --------------------------------------------------
  // two's complement add covers the signed immediate
  assign vaddr    = operand_a_i + imm_i;
  assign is_store = lsu_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};

  always_comb begin
    case (lsu_op_i)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: size = lsu_pkg::SIZE_BYTE;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: size = lsu_pkg::SIZE_HALF;
      default:                                size = lsu_pkg::SIZE_WORD;
    endcase
  end

  always_comb begin
    case (size)
      lsu_pkg::SIZE_BYTE: be = lsu_pkg::be_t'(1) << vaddr[lsu_pkg::OFFSET_BITS-1:0];
      lsu_pkg::SIZE_HALF: be = lsu_pkg::be_t'(3) << vaddr[lsu_pkg::OFFSET_BITS-1:0];
      default:            be = '1;
    endcase
  end

  // --------------------------------------------------
  // exception checks
  // --------------------------------------------------
  assign misaligned = ((size == lsu_pkg::SIZE_HALF) && vaddr[0]) ||
                      ((size == lsu_pkg::SIZE_WORD) && (vaddr[lsu_pkg::OFFSET_BITS-1:0] != '0));

  // replaces the virtual address overflow check
  assign access_fault = (vaddr >= MEM_BYTES);

  // misalignment wins over the range check
  always_comb begin
    cause = '0;
    if (misaligned) begin
      cause = is_store ? lsu_pkg::CAUSE_ST_MISALIGNED : lsu_pkg::CAUSE_LD_MISALIGNED;
    end else if (access_fault) begin
      cause = is_store ? lsu_pkg::CAUSE_ST_ACCESS_FAULT : lsu_pkg::CAUSE_LD_ACCESS_FAULT;
    end
  end

  // --------------------------------------------------
  // first register stage
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= lsu_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    op_o       <= lsu_op_i;
    vaddr_o    <= vaddr;
    be_o       <= be;
    wdata_o    <= operand_b_i;
    trans_id_o <= trans_id_i;
    ex_valid_o <= lsu_valid_i & (misaligned | access_fault);
    ex_cause_o <= cause;
  end

endmodule

/* hdl/lsu_store_unit.sv */
`timescale 1ns/1ps

module lsu_store_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  input  lsu_pkg::lsu_op_e   op_i,
  input  lsu_pkg::xlen_t     vaddr_i,
  input  lsu_pkg::be_t       be_i,
  input  lsu_pkg::xlen_t     wdata_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  input  logic               ex_valid_i,
  input  lsu_pkg::cause_t    ex_cause_i,
  output logic               mem_we_o,
  output lsu_pkg::xlen_t     mem_addr_o,
  output lsu_pkg::be_t       mem_be_o,
  output lsu_pkg::xlen_t     mem_wdata_o,
  output logic               st_valid_o,
  output lsu_pkg::trans_id_t st_trans_id_o,
  output logic               st_ex_valid_o,
  output lsu_pkg::cause_t    st_ex_cause_o,
  output lsu_pkg::xlen_t     st_ex_tval_o
);

  logic st_req;
  logic st_fault;

  assign st_req   = valid_i & (op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW});
  assign st_fault = st_req & ex_valid_i;

  // --------------------------------------------------
  // memory write
  // --------------------------------------------------
  // move the data up to the lane picked by the byte offset
  assign mem_wdata_o = wdata_i << {vaddr_i[lsu_pkg::OFFSET_BITS-1:0], 3'b000};
  assign mem_addr_o  = {{lsu_pkg::OFFSET_BITS{1'b0}}, vaddr_i[lsu_pkg::XLEN-1:lsu_pkg::OFFSET_BITS]};
  assign mem_be_o    = be_i;
  assign mem_we_o    = st_req & ~ex_valid_i;

  // --------------------------------------------------
  // writeback
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_valid_o    <= 1'b0;
      st_ex_valid_o <= 1'b0;
    end else begin
      st_valid_o    <= st_req;
      st_ex_valid_o <= st_fault;
    end
  end

  // cause and tval read as zero without a fault
  always_ff @(posedge clk_i) begin
    st_trans_id_o <= trans_id_i;
    st_ex_cause_o <= st_fault ? ex_cause_i : '0;
    st_ex_tval_o  <= st_fault ? vaddr_i : '0;
  end

endmodule

/* hdl/lsu_load_unit.sv */
`timescale 1ns/1ps

module lsu_load_unit (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               valid_i,
  input  lsu_pkg::lsu_op_e   op_i,
  input  lsu_pkg::xlen_t     vaddr_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  input  logic               ex_valid_i,
  input  lsu_pkg::cause_t    ex_cause_i,
  input  lsu_pkg::xlen_t     mem_rdata_i,
  output logic               mem_re_o,
  output lsu_pkg::xlen_t     mem_raddr_o,
  output logic               ld_valid_o,
  output lsu_pkg::trans_id_t ld_trans_id_o,
  output lsu_pkg::xlen_t     ld_result_o,
  output logic               ld_ex_valid_o,
  output lsu_pkg::cause_t    ld_ex_cause_o,
  output lsu_pkg::xlen_t     ld_ex_tval_o
);

  logic             ld_req;
  logic             ld_fault;
  lsu_pkg::lsu_op_e op_q;
  lsu_pkg::xlen_t   vaddr_q;
  lsu_pkg::cause_t  cause_q;
  lsu_pkg::xlen_t   shifted;

  assign ld_req   = valid_i & (op_i inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                            lsu_pkg::LHU, lsu_pkg::LW});
  assign ld_fault = ld_req & ex_valid_i;

  // a faulting load never touches the memory
  assign mem_re_o    = ld_req & ~ex_valid_i;
  assign mem_raddr_o = {{lsu_pkg::OFFSET_BITS{1'b0}}, vaddr_i[lsu_pkg::XLEN-1:lsu_pkg::OFFSET_BITS]};

  // --------------------------------------------------
  // request info held across the memory read
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ld_valid_o    <= 1'b0;
      ld_ex_valid_o <= 1'b0;
    end else begin
      ld_valid_o    <= ld_req;
      ld_ex_valid_o <= ld_fault;
    end
  end

  always_ff @(posedge clk_i) begin
    op_q          <= op_i;
    vaddr_q       <= vaddr_i;
    ld_trans_id_o <= trans_id_i;
    cause_q       <= ld_fault ? ex_cause_i : '0;
  end

  assign ld_ex_cause_o = cause_q;
  assign ld_ex_tval_o  = ld_ex_valid_o ? vaddr_q : '0;

  // --------------------------------------------------
  // realign and extend
  // --------------------------------------------------
  assign shifted = mem_rdata_i >> {vaddr_q[lsu_pkg::OFFSET_BITS-1:0], 3'b000};

  always_comb begin
    ld_result_o = '0;
    if (ld_valid_o && !ld_ex_valid_o) begin
      case (op_q)
        lsu_pkg::LB:  ld_result_o = {{(lsu_pkg::XLEN-8){shifted[7]}}, shifted[7:0]};
        lsu_pkg::LBU: ld_result_o = {{(lsu_pkg::XLEN-8){1'b0}}, shifted[7:0]};
        lsu_pkg::LH:  ld_result_o = {{(lsu_pkg::XLEN-16){shifted[15]}}, shifted[15:0]};
        lsu_pkg::LHU: ld_result_o = {{(lsu_pkg::XLEN-16){1'b0}}, shifted[15:0]};
        default:      ld_result_o = shifted;
      endcase
    end
  end

endmodule

/* hdl/lsu_scratchpad.sv */
`timescale 1ns/1ps

module lsu_scratchpad #(
  parameter int unsigned MEM_WORDS = 256
) (
  input  logic           clk_i,
  input  logic           we_i,
  input  lsu_pkg::xlen_t waddr_i,
  input  lsu_pkg::be_t   be_i,
  input  lsu_pkg::xlen_t wdata_i,
  input  logic           re_i,
  input  lsu_pkg::xlen_t raddr_i,
  output lsu_pkg::xlen_t rdata_o
);

  localparam int unsigned AW = $clog2(MEM_WORDS);

  lsu_pkg::xlen_t mem_q [MEM_WORDS];

  // byte lanes written independently
  always_ff @(posedge clk_i) begin
    if (we_i) begin
      for (int i = 0; i < lsu_pkg::NR_BYTES; i++) begin
        if (be_i[i]) begin
          mem_q[waddr_i[AW-1:0]][i*8 +: 8] <= wdata_i[i*8 +: 8];
        end
      end
    end
  end

  // read data holds until the next read
  always_ff @(posedge clk_i) begin
    if (re_i) begin
      rdata_o <= mem_q[raddr_i[AW-1:0]];
    end
  end

endmodule

/* hdl/lsu_pipe_reg.sv */
`timescale 1ns/1ps

module lsu_pipe_reg #(
  parameter int unsigned NR_PIPE_REGS = 1,
  parameter int unsigned W            = 1
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic [W-1:0] d_i,
  output logic [W-1:0] d_o
);

  // more stages shorten the return path, at the cost of latency
  logic [W-1:0] stage_q [NR_PIPE_REGS];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NR_PIPE_REGS; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= d_i;
      for (int i = 1; i < NR_PIPE_REGS; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign d_o = stage_q[NR_PIPE_REGS-1];

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
  parameter int unsigned MEM_WORDS    = 256,
  parameter int unsigned NR_PIPE_REGS = 1
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               lsu_valid_i,
  input  lsu_pkg::lsu_op_e   lsu_op_i,
  input  lsu_pkg::xlen_t     operand_a_i,
  input  lsu_pkg::xlen_t     imm_i,
  input  lsu_pkg::xlen_t     operand_b_i,
  input  lsu_pkg::trans_id_t trans_id_i,
  output logic               load_valid_o,
  output lsu_pkg::trans_id_t load_trans_id_o,
  output lsu_pkg::xlen_t     load_result_o,
  output logic               load_ex_valid_o,
  output lsu_pkg::cause_t    load_ex_cause_o,
  output lsu_pkg::xlen_t     load_ex_tval_o,
  output logic               store_valid_o,
  output lsu_pkg::trans_id_t store_trans_id_o,
  output lsu_pkg::xlen_t     store_result_o,
  output logic               store_ex_valid_o,
  output lsu_pkg::cause_t    store_ex_cause_o,
  output lsu_pkg::xlen_t     store_ex_tval_o
);

  // valid, id, result, ex valid, cause, tval
  localparam int unsigned WB_W = 2 + lsu_pkg::TRANS_ID_BITS + 2 * lsu_pkg::XLEN +
                                 $bits(lsu_pkg::cause_t);

  // --------------------------------------------------
  // stage 1
  // --------------------------------------------------
  logic               s1_valid;
  lsu_pkg::lsu_op_e   s1_op;
  lsu_pkg::xlen_t     s1_vaddr;
  lsu_pkg::be_t       s1_be;
  lsu_pkg::xlen_t     s1_wdata;
  lsu_pkg::trans_id_t s1_trans_id;
  logic               s1_ex_valid;
  lsu_pkg::cause_t    s1_ex_cause;

  // scratchpad
  logic               mem_we;
  lsu_pkg::xlen_t     mem_waddr;
  lsu_pkg::be_t       mem_be;
  lsu_pkg::xlen_t     mem_wdata;
  logic               mem_re;
  lsu_pkg::xlen_t     mem_raddr;
  lsu_pkg::xlen_t     mem_rdata;

  // writeback into the output registers
  logic               ld_valid;
  lsu_pkg::trans_id_t ld_trans_id;
  lsu_pkg::xlen_t     ld_result;
  logic               ld_ex_valid;
  lsu_pkg::cause_t    ld_ex_cause;
  lsu_pkg::xlen_t     ld_ex_tval;
  logic               st_valid;
  lsu_pkg::trans_id_t st_trans_id;
  logic               st_ex_valid;
  lsu_pkg::cause_t    st_ex_cause;
  lsu_pkg::xlen_t     st_ex_tval;

  lsu_agu #(.MEM_WORDS(MEM_WORDS)) i_agu (
    .clk_i, .rst_ni, .lsu_valid_i, .lsu_op_i, .operand_a_i, .imm_i, .operand_b_i, .trans_id_i,
    .valid_o(s1_valid), .op_o(s1_op), .vaddr_o(s1_vaddr), .be_o(s1_be), .wdata_o(s1_wdata),
    .trans_id_o(s1_trans_id), .ex_valid_o(s1_ex_valid), .ex_cause_o(s1_ex_cause)
  );

  lsu_store_unit i_store_unit (
    .clk_i, .rst_ni, .valid_i(s1_valid), .op_i(s1_op), .vaddr_i(s1_vaddr), .be_i(s1_be),
    .wdata_i(s1_wdata), .trans_id_i(s1_trans_id), .ex_valid_i(s1_ex_valid),
    .ex_cause_i(s1_ex_cause), .mem_we_o(mem_we), .mem_addr_o(mem_waddr), .mem_be_o(mem_be),
    .mem_wdata_o(mem_wdata), .st_valid_o(st_valid), .st_trans_id_o(st_trans_id),
    .st_ex_valid_o(st_ex_valid), .st_ex_cause_o(st_ex_cause), .st_ex_tval_o(st_ex_tval)
  );

  lsu_load_unit i_load_unit (
    .clk_i, .rst_ni, .valid_i(s1_valid), .op_i(s1_op), .vaddr_i(s1_vaddr),
    .trans_id_i(s1_trans_id), .ex_valid_i(s1_ex_valid), .ex_cause_i(s1_ex_cause),
    .mem_rdata_i(mem_rdata), .mem_re_o(mem_re), .mem_raddr_o(mem_raddr),
    .ld_valid_o(ld_valid), .ld_trans_id_o(ld_trans_id), .ld_result_o(ld_result),
    .ld_ex_valid_o(ld_ex_valid), .ld_ex_cause_o(ld_ex_cause), .ld_ex_tval_o(ld_ex_tval)
  );

  lsu_scratchpad #(.MEM_WORDS(MEM_WORDS)) i_scratchpad (
    .clk_i, .we_i(mem_we), .waddr_i(mem_waddr), .be_i(mem_be), .wdata_i(mem_wdata),
    .re_i(mem_re), .raddr_i(mem_raddr), .rdata_o(mem_rdata)
  );

  // --------------------------------------------------
  // output pipeline registers
  // --------------------------------------------------
  lsu_pipe_reg #(.NR_PIPE_REGS(NR_PIPE_REGS), .W(WB_W)) i_pipe_reg_load (
    .clk_i, .rst_ni,
    .d_i({ld_valid, ld_trans_id, ld_result, ld_ex_valid, ld_ex_cause, ld_ex_tval}),
    .d_o({load_valid_o, load_trans_id_o, load_result_o, load_ex_valid_o, load_ex_cause_o,
          load_ex_tval_o})
  );

  // stores return no data
  lsu_pipe_reg #(.NR_PIPE_REGS(NR_PIPE_REGS), .W(WB_W)) i_pipe_reg_store (
    .clk_i, .rst_ni,
    .d_i({st_valid, st_trans_id, lsu_pkg::xlen_t'(0), st_ex_valid, st_ex_cause, st_ex_tval}),
    .d_o({store_valid_o, store_trans_id_o, store_result_o, store_ex_valid_o, store_ex_cause_o,
          store_ex_tval_o})
  );

endmodule

/* verification/lsu_props.sv */
`timescale 1ns/1ps

module lsu_props #(
  parameter int unsigned NR_PIPE_REGS = 1
) (
  input logic             clk_i,
  input logic             rst_ni,
  input logic             lsu_valid_i,
  input lsu_pkg::lsu_op_e lsu_op_i,
  input logic             load_valid_o,
  input logic             store_valid_o
);

  // request to writeback, in cycles
  localparam int unsigned LATENCY = 2 + NR_PIPE_REGS;

  logic ld_accept;
  logic st_accept;

  // number of assertion failures so far
  int fail_count = 0;

  assign ld_accept = lsu_valid_i && (lsu_op_i inside {lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::LH,
                                                      lsu_pkg::LHU, lsu_pkg::LW});
  assign st_accept = lsu_valid_i && (lsu_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW});

  valid_low_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> (!load_valid_o && !store_valid_o)
  ) else begin
    $error("writeback valid high while reset is asserted");
    fail_count++;
  end

  load_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni) ld_accept |-> ##LATENCY load_valid_o
  ) else begin
    $error("load writeback missing %0d cycles after acceptance", LATENCY);
    fail_count++;
  end

  store_latency: assert property (
    @(posedge clk_i) disable iff (!rst_ni) st_accept |-> ##LATENCY store_valid_o
  ) else begin
    $error("store writeback missing %0d cycles after acceptance", LATENCY);
    fail_count++;
  end

endmodule

/* verification/lsu_checker.sv */
`timescale 1ns/1ps

module lsu_checker #(
  parameter int unsigned MEM_WORDS = 256
) (
  input logic               clk_i,
  input logic               rst_ni,
  input logic               lsu_valid_i,
  input lsu_pkg::lsu_op_e   lsu_op_i,
  input lsu_pkg::xlen_t     operand_a_i,
  input lsu_pkg::xlen_t     imm_i,
  input lsu_pkg::xlen_t     operand_b_i,
  input lsu_pkg::trans_id_t trans_id_i,
  input logic               load_valid_i,
  input lsu_pkg::trans_id_t load_trans_id_i,
  input lsu_pkg::xlen_t     load_result_i,
  input logic               load_ex_valid_i,
  input lsu_pkg::cause_t    load_ex_cause_i,
  input lsu_pkg::xlen_t     load_ex_tval_i,
  input logic               store_valid_i,
  input lsu_pkg::trans_id_t store_trans_id_i,
  input lsu_pkg::xlen_t     store_result_i,
  input logic               store_ex_valid_i,
  input lsu_pkg::cause_t    store_ex_cause_i,
  input lsu_pkg::xlen_t     store_ex_tval_i
);

  // ex valid, cause, tval, result
  typedef logic [4 + 2 * lsu_pkg::XLEN : 0] wb_t;
  // id in front of the writeback
  typedef logic [lsu_pkg::TRANS_ID_BITS + $bits(wb_t) - 1 : 0] entry_t;

  string      test_name = "none";
  int         error_count = 0;
  logic [7:0] mem_model [MEM_WORDS * 4];
  entry_t     ld_q [$];
  entry_t     st_q [$];

  // --------------------------------------------------
  // reference model
  // --------------------------------------------------
  function automatic int unsigned op_bytes(lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic wb_t ref_writeback(lsu_pkg::lsu_op_e op, lsu_pkg::xlen_t addr);
    int unsigned     nbytes;
    logic            store;
    lsu_pkg::xlen_t  data;
    lsu_pkg::cause_t cause;
    nbytes = op_bytes(op);
    store  = op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW};
    if ((addr % nbytes) != 0) begin
      cause = store ? lsu_pkg::CAUSE_ST_MISALIGNED : lsu_pkg::CAUSE_LD_MISALIGNED;
      return {1'b1, cause, addr, lsu_pkg::xlen_t'(0)};
    end
    if (addr >= MEM_WORDS * 4) begin
      cause = store ? lsu_pkg::CAUSE_ST_ACCESS_FAULT : lsu_pkg::CAUSE_LD_ACCESS_FAULT;
      return {1'b1, cause, addr, lsu_pkg::xlen_t'(0)};
    end
    if (store) begin
      return '0;
    end
    data = '0;
    for (int i = 0; i < nbytes; i++) begin
      data[i*8 +: 8] = mem_model[addr + i];
    end
    if (op == lsu_pkg::LB) begin
      data = {{24{data[7]}}, data[7:0]};
    end else if (op == lsu_pkg::LH) begin
      data = {{16{data[15]}}, data[15:0]};
    end
    return {1'b0, 4'h0, lsu_pkg::xlen_t'(0), data};
  endfunction

  task automatic compare_wb(string path, entry_t expected, entry_t actual);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED: [%s] %s writeback expected %h, actual %h",
               test_name, path, expected, actual);
    end
  endtask

  function automatic int pending();
    return ld_q.size() + st_q.size();
  endfunction

  task automatic report_pending();
    if (pending() != 0) begin
      error_count += pending();
      $display("ERROR: [%s] %0d load and %0d store requests never got a writeback",
               test_name, ld_q.size(), st_q.size());
      ld_q.delete();
      st_q.delete();
    end
  endtask

  // --------------------------------------------------
  // compare, then record new requests
  // --------------------------------------------------
  always @(posedge clk_i or negedge rst_ni) begin : watch
    lsu_pkg::xlen_t addr;
    wb_t            expected;
    if (!rst_ni) begin
      // requests in flight are dropped by reset
      ld_q.delete();
      st_q.delete();
    end else begin
      if (load_valid_i) begin
        if (ld_q.size() == 0) begin
          error_count++;
          $display("ERROR: [%s] load writeback arrived with no load outstanding", test_name);
        end else begin
          compare_wb("load", ld_q.pop_front(), {load_trans_id_i, load_ex_valid_i,
                     load_ex_cause_i, load_ex_tval_i, load_result_i});
        end
      end
      if (store_valid_i) begin
        if (st_q.size() == 0) begin
          error_count++;
          $display("ERROR: [%s] store writeback arrived with no store outstanding", test_name);
        end else begin
          compare_wb("store", st_q.pop_front(), {store_trans_id_i, store_ex_valid_i,
                     store_ex_cause_i, store_ex_tval_i, store_result_i});
        end
      end
      if (lsu_valid_i) begin
        addr     = operand_a_i + imm_i;
        expected = ref_writeback(lsu_op_i, addr);
        if (lsu_op_i inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW}) begin
          st_q.push_back({trans_id_i, expected});
          if (!expected[$bits(wb_t)-1]) begin
            for (int i = 0; i < op_bytes(lsu_op_i); i++) begin
              mem_model[addr + i] = operand_b_i[i*8 +: 8];
            end
          end
        end else begin
          ld_q.push_back({trans_id_i, expected});
        end
      end
    end
  end

endmodule

/* verification/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

  localparam int unsigned MEM_WORDS     = 256;
  localparam int unsigned NR_PIPE_REGS  = 1;
  localparam int          NR_RANDOM     = 200;
  localparam int          DIRECTED_REQS = 50;
  localparam int          FILL_REQS     = 16;
  localparam int          DRAIN_LIMIT   = 20;
  localparam int          MARGIN_NS     = 3000;
  // random stores may each be followed by a load
  localparam int          NR_REQUESTS   = DIRECTED_REQS + FILL_REQS + 2 * NR_RANDOM;
  localparam int          TIMEOUT_NS    = NR_REQUESTS * 10 + MARGIN_NS;

  logic               clk;
  logic               rst_n;
  logic               lsu_valid;
  lsu_pkg::lsu_op_e   lsu_op;
  lsu_pkg::xlen_t     operand_a;
  lsu_pkg::xlen_t     imm;
  lsu_pkg::xlen_t     operand_b;
  lsu_pkg::trans_id_t trans_id;
  logic               load_valid;
  lsu_pkg::trans_id_t load_trans_id;
  lsu_pkg::xlen_t     load_result;
  logic               load_ex_valid;
  lsu_pkg::cause_t    load_ex_cause;
  lsu_pkg::xlen_t     load_ex_tval;
  logic               store_valid;
  lsu_pkg::trans_id_t store_trans_id;
  lsu_pkg::xlen_t     store_result;
  logic               store_ex_valid;
  lsu_pkg::cause_t    store_ex_cause;
  lsu_pkg::xlen_t     store_ex_tval;

  int seed         = 42403;
  int tests_run    = 0;
  int tests_failed = 0;
  int errors_at_start;

  lsu_top #(.MEM_WORDS(MEM_WORDS), .NR_PIPE_REGS(NR_PIPE_REGS)) dut (
    .clk_i(clk), .rst_ni(rst_n), .lsu_valid_i(lsu_valid), .lsu_op_i(lsu_op),
    .operand_a_i(operand_a), .imm_i(imm), .operand_b_i(operand_b), .trans_id_i(trans_id),
    .load_valid_o(load_valid), .load_trans_id_o(load_trans_id), .load_result_o(load_result),
    .load_ex_valid_o(load_ex_valid), .load_ex_cause_o(load_ex_cause),
    .load_ex_tval_o(load_ex_tval), .store_valid_o(store_valid),
    .store_trans_id_o(store_trans_id), .store_result_o(store_result),
    .store_ex_valid_o(store_ex_valid), .store_ex_cause_o(store_ex_cause),
    .store_ex_tval_o(store_ex_tval)
  );

  lsu_checker #(.MEM_WORDS(MEM_WORDS)) chk (
    .clk_i(clk), .rst_ni(rst_n), .lsu_valid_i(lsu_valid), .lsu_op_i(lsu_op),
    .operand_a_i(operand_a), .imm_i(imm), .operand_b_i(operand_b), .trans_id_i(trans_id),
    .load_valid_i(load_valid), .load_trans_id_i(load_trans_id), .load_result_i(load_result),
    .load_ex_valid_i(load_ex_valid), .load_ex_cause_i(load_ex_cause),
    .load_ex_tval_i(load_ex_tval), .store_valid_i(store_valid),
    .store_trans_id_i(store_trans_id), .store_result_i(store_result),
    .store_ex_valid_i(store_ex_valid), .store_ex_cause_i(store_ex_cause),
    .store_ex_tval_i(store_ex_tval)
  );

  bind lsu_top lsu_props #(.NR_PIPE_REGS(NR_PIPE_REGS)) i_props (.*);

  // starts high so the first edge is a falling one
  initial begin
    clk = 1'b1;
    forever #5 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("ERROR: timeout, the tests did not finish within %0d ns", TIMEOUT_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // checker mismatches plus failed assertions
  function automatic int total_errors();
    return chk.error_count + dut.i_props.fail_count;
  endfunction

  // --------------------------------------------------
  // stimulus helpers, called on a falling edge
  // --------------------------------------------------
  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic issue(lsu_pkg::lsu_op_e op, lsu_pkg::xlen_t base, lsu_pkg::xlen_t offset,
                       lsu_pkg::xlen_t data);
    lsu_valid = 1'b1;
    lsu_op    = op;
    operand_a = base;
    imm       = offset;
    operand_b = data;
    @(negedge clk);
    lsu_valid = 1'b0;
    trans_id  = trans_id + 1'b1;
  endtask

  task automatic begin_test(string name);
    chk.test_name   = name;
    errors_at_start = total_errors();
  endtask

  task automatic finish_test();
    int cycles;
    int errors;
    cycles = 0;
    while (chk.pending() != 0 && cycles < DRAIN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    chk.report_pending();
    repeat (2) @(negedge clk);
    errors = total_errors() - errors_at_start;
    tests_run++;
    if (errors != 0) begin
      tests_failed++;
    end
    $display("test %-18s %s (%0d errors)", chk.test_name, (errors == 0) ? "ok" : "failed",
             errors);
  endtask

  // --------------------------------------------------
  // tests
  // --------------------------------------------------
  // nothing may come out while idle
  task automatic reset_idle();
    begin_test("reset_idle");
    repeat (8) @(negedge clk);
    finish_test();
  endtask

  task automatic store_load_sizes();
    begin_test("store_load_sizes");
    issue(lsu_pkg::SW, 32'h10, 0, 32'hdead_beef);
    issue(lsu_pkg::LW, 32'h20, 32'hffff_fff0, 0);
    issue(lsu_pkg::LB, 32'h13, 0, 0);
    issue(lsu_pkg::LBU, 32'h13, 0, 0);
    issue(lsu_pkg::LH, 32'h12, 0, 0);
    issue(lsu_pkg::LHU, 32'h12, 0, 0);
    issue(lsu_pkg::LBU, 32'h10, 0, 0);
    issue(lsu_pkg::SH, 32'h1c, 32'h4, 32'h1234_8001);
    issue(lsu_pkg::LH, 32'h20, 0, 0);
    issue(lsu_pkg::LHU, 32'h20, 0, 0);
    issue(lsu_pkg::SB, 32'h31, 0, 32'hffff_ff80);
    issue(lsu_pkg::LB, 32'h31, 0, 0);
    issue(lsu_pkg::LBU, 32'h31, 0, 0);
    finish_test();
  endtask

  task automatic lane_merge();
    begin_test("lane_merge");
    issue(lsu_pkg::SW, 32'h40, 0, 32'h1122_3344);
    issue(lsu_pkg::SB, 32'h41, 0, 32'h0000_00aa);
    issue(lsu_pkg::SH, 32'h42, 0, 32'h0000_bbcc);
    issue(lsu_pkg::LW, 32'h40, 0, 0);
    issue(lsu_pkg::SB, 32'h43, 0, 32'h0000_0055);
    issue(lsu_pkg::LW, 32'h40, 0, 0);
    finish_test();
  endtask

  task automatic misaligned();
    begin_test("misaligned");
    issue(lsu_pkg::SW, 32'h50, 0, 32'h0102_0304);
    issue(lsu_pkg::SW, 32'h51, 0, 32'hffff_ffff);
    issue(lsu_pkg::SH, 32'h53, 0, 32'hffff_ffff);
    issue(lsu_pkg::SW, 32'h52, 0, 32'hffff_ffff);
    issue(lsu_pkg::LH, 32'h51, 0, 0);
    issue(lsu_pkg::LW, 32'h52, 0, 0);
    issue(lsu_pkg::LW, 32'h50, 0, 0);
    finish_test();
  endtask

  task automatic access_fault();
    begin_test("access_fault");
    issue(lsu_pkg::SW, 32'h0, 0, 32'hcafe_0001);
    issue(lsu_pkg::SW, 32'h400, 0, 32'h5555_5555);
    issue(lsu_pkg::SB, 32'h403, 0, 32'h0000_0077);
    issue(lsu_pkg::LW, 32'h400, 0, 0);
    issue(lsu_pkg::LB, 32'h0, 32'hffff_fff0, 0);
    issue(lsu_pkg::LW, 32'h401, 0, 0);
    issue(lsu_pkg::LW, 32'h0, 0, 0);
    issue(lsu_pkg::SW, 32'h3fc, 0, 32'h0bad_f00d);
    issue(lsu_pkg::LW, 32'h3fc, 0, 0);
    finish_test();
  endtask

  task automatic random_mix();
    lsu_pkg::xlen_t   rnd;
    lsu_pkg::xlen_t   addr;
    lsu_pkg::xlen_t   offset;
    lsu_pkg::lsu_op_e op;
    begin_test("random_mix");
    // known data in the whole window first
    for (int w = 0; w < FILL_REQS; w++) begin
      issue(lsu_pkg::SW, 32'h100 + 4 * w, 0, $random(seed));
    end
    for (int i = 0; i < NR_RANDOM; i++) begin
      rnd    = $random(seed);
      op     = lsu_pkg::lsu_op_e'(rnd[2:0]);
      addr   = 32'h100 + rnd[8:3];
      offset = {{28{rnd[12]}}, rnd[12:9]};
      issue(op, addr - offset, offset, $random(seed));
      if (op inside {lsu_pkg::SB, lsu_pkg::SH, lsu_pkg::SW} && rnd[13]) begin
        issue(lsu_pkg::LW, addr & 32'hffff_fffc, 0, 0);
      end
    end
    finish_test();
  endtask

  // loads only, so no killed store leaves the model ahead of memory
  task automatic mid_run_reset();
    begin_test("mid_run_reset");
    issue(lsu_pkg::LW, 32'h40, 0, 0);
    issue(lsu_pkg::LW, 32'h10, 0, 0);
    issue(lsu_pkg::LBU, 32'h31, 0, 0);
    apply_reset();
    repeat (6) @(negedge clk);
    issue(lsu_pkg::LW, 32'h40, 0, 0);
    finish_test();
  endtask

  initial begin
    rst_n     = 1'b1;
    lsu_valid = 1'b0;
    lsu_op    = lsu_pkg::LW;
    operand_a = '0;
    imm       = '0;
    operand_b = '0;
    trans_id  = '0;
    @(negedge clk);
    apply_reset();

    reset_idle();
    store_load_sizes();
    lane_merge();
    misaligned();
    access_fault();
    random_mix();
    mid_run_reset();

    $display("tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed,
             total_errors());
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* lsu.f */
hdl/lsu_pkg.sv
hdl/lsu_agu.sv
hdl/lsu_store_unit.sv
hdl/lsu_load_unit.sv
hdl/lsu_scratchpad.sv
hdl/lsu_pipe_reg.sv
hdl/lsu_top.sv
verification/lsu_props.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - hdl/lsu_pkg.sv
  - hdl/lsu_agu.sv
  - hdl/lsu_store_unit.sv
  - hdl/lsu_load_unit.sv
  - hdl/lsu_scratchpad.sv
  - hdl/lsu_pipe_reg.sv
  - hdl/lsu_top.sv
  - target: test
    files:
      - verification/lsu_props.sv
      - verification/lsu_checker.sv
      - verification/lsu_tb.sv
